//--- Makefile
TOOL       := verilator
TOP        := uce_tb
FILELIST   := tb.f
FLAGS      := --timing -Wno-fatal
LINT_FLAGS := --lint-only
SIM_FLAGS  := --binary
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := SOME TESTS FAILED

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(FLAGS) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported errors"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/uce_cfg.svh
`ifndef UCE_CFG_SVH
`define UCE_CFG_SVH

// Physical address width in bits
`define UCE_PADDR_WIDTH 32

// One cache block and one memory beat
`define UCE_BLOCK_WIDTH 128
`define UCE_FILL_WIDTH 64
`define UCE_DWORD_WIDTH 64

// Cache geometry
`define UCE_SETS 64
`define UCE_WAYS 4

// Outstanding memory requests allowed at once
`define UCE_MAX_CREDITS 4

`endif

//--- common/uce_pkg.sv
`default_nettype none

`include "uce_cfg.svh"

package uce_pkg;

  localparam int unsigned paddr_width = `UCE_PADDR_WIDTH;
  localparam int unsigned block_width = `UCE_BLOCK_WIDTH;
  localparam int unsigned fill_width = `UCE_FILL_WIDTH;
  localparam int unsigned dword_width = `UCE_DWORD_WIDTH;
  localparam int unsigned size_width = 3;

  localparam int unsigned index_width = $clog2(`UCE_SETS);
  localparam int unsigned way_width = $clog2(`UCE_WAYS);
  localparam int unsigned block_offset_width = $clog2(block_width / 8);
  localparam int unsigned fill_offset_width = $clog2(fill_width / 8);
  localparam int unsigned tag_width = paddr_width - index_width - block_offset_width;
  localparam int unsigned block_beats = block_width / fill_width;
  localparam int unsigned fill_cnt_width = (block_beats > 1) ? $clog2(block_beats) : 1;

  // Size codes are log2 of the byte count
  localparam logic [size_width-1:0] block_size_code = size_width'($clog2(block_width / 8));

  typedef enum logic [1:0]
  {
    e_req_miss_load,
    e_req_uc_load,
    e_req_uc_store,
    e_req_clear
  } uce_req_type_e;

  typedef struct packed
  {
    uce_req_type_e          msg_type;
    logic [paddr_width-1:0] addr;
    logic [size_width-1:0]  size;
    logic [way_width-1:0]   way;
    logic [dword_width-1:0] data;
  } uce_cache_req_s;

  typedef enum logic [1:0]
  {
    e_mem_rd,
    e_mem_uc_rd,
    e_mem_uc_wr
  } uce_mem_type_e;

  typedef struct packed
  {
    uce_mem_type_e          msg_type;
    logic [paddr_width-1:0] addr;
    logic [size_width-1:0]  size;
  } uce_mem_header_s;

  typedef struct packed
  {
    uce_mem_header_s       header;
    logic [fill_width-1:0] data;
  } uce_mem_cmd_s;

  typedef struct packed
  {
    uce_mem_header_s       header;
    logic [fill_width-1:0] data;
    logic                  last;
  } uce_mem_resp_s;

  // One response beat with its own address and its position in the block
  typedef struct packed
  {
    uce_mem_header_s        header;
    logic [paddr_width-1:0] addr;
    logic [block_beats-1:0] fill_index;
    logic [fill_width-1:0]  data;
    logic                   last;
  } uce_resp_beat_s;

  typedef enum logic
  {
    e_tag_clear,
    e_tag_set_tag
  } uce_tag_op_e;

  typedef struct packed
  {
    uce_tag_op_e            opcode;
    logic [index_width-1:0] index;
    logic [way_width-1:0]   way;
    logic [tag_width-1:0]   tag;
  } uce_tag_pkt_s;

  typedef enum logic
  {
    e_data_write,
    e_data_uncached
  } uce_data_op_e;

  typedef struct packed
  {
    uce_data_op_e           opcode;
    logic [index_width-1:0] index;
    logic [way_width-1:0]   way;
    logic [block_beats-1:0] fill_index;
    logic [fill_width-1:0]  data;
  } uce_data_pkt_s;

endpackage

`default_nettype wire

//--- design/uce_resp_pump.sv
`timescale 1ns/1ps
`default_nettype none

module uce_resp_pump
  (
    input  logic                    clk_i,
    input  logic                    reset_i,

    input  uce_pkg::uce_mem_resp_s  mem_resp_i,
    input  logic                    mem_resp_v_i,
    output logic                    mem_resp_ready_o,

    output uce_pkg::uce_resp_beat_s beat_o,
    output logic                    beat_v_o,
    input  logic                    beat_ready_i
  );

  import uce_pkg::*;

  // Beat position inside the current response
  logic [fill_cnt_width-1:0] cnt_r;
  logic                      beat_hs;

  assign beat_v_o = mem_resp_v_i;
  assign mem_resp_ready_o = beat_ready_i;
  assign beat_hs = mem_resp_v_i & beat_ready_i;

  // The header address is the base of the burst, each beat steps one fill width
  always_comb
  begin
    beat_o.header = mem_resp_i.header;
    beat_o.addr = mem_resp_i.header.addr + (paddr_width'(cnt_r) << fill_offset_width);
    beat_o.fill_index = block_beats'(1) << cnt_r;
    beat_o.data = mem_resp_i.data;
    beat_o.last = mem_resp_i.last;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      cnt_r <= '0;
    end
    else if (beat_hs)
    begin
      if (mem_resp_i.last)
        cnt_r <= '0;
      else
        cnt_r <= cnt_r + fill_cnt_width'(1);
    end
  end

endmodule

`default_nettype wire

//--- design/uce_top.sv
`timescale 1ns/1ps
`default_nettype none

module uce_top
  (
    input  logic                   clk_i,
    input  logic                   reset_i,

    input  uce_pkg::uce_cache_req_s cache_req_i,
    input  logic                   cache_req_v_i,
    output logic                   cache_req_ready_o,
    output logic                   cache_req_complete_o,
    output logic                   cache_req_busy_o,

    output uce_pkg::uce_tag_pkt_s  tag_pkt_o,
    output logic                   tag_pkt_v_o,
    input  logic                   tag_pkt_yumi_i,

    output uce_pkg::uce_data_pkt_s data_pkt_o,
    output logic                   data_pkt_v_o,
    input  logic                   data_pkt_yumi_i,

    output uce_pkg::uce_mem_cmd_s  mem_cmd_o,
    output logic                   mem_cmd_v_o,
    input  logic                   mem_cmd_ready_i,

    input  uce_pkg::uce_mem_resp_s mem_resp_i,
    input  logic                   mem_resp_v_i,
    output logic                   mem_resp_ready_o
  );

  import uce_pkg::*;

  uce_resp_beat_s beat;
  logic           beat_v;
  logic           beat_ready;

  uce_ctrl ctrl0
    (
      .clk_i                (clk_i),
      .reset_i              (reset_i),
      .cache_req_i          (cache_req_i),
      .cache_req_v_i        (cache_req_v_i),
      .cache_req_ready_o    (cache_req_ready_o),
      .cache_req_complete_o (cache_req_complete_o),
      .cache_req_busy_o     (cache_req_busy_o),
      .tag_pkt_o            (tag_pkt_o),
      .tag_pkt_v_o          (tag_pkt_v_o),
      .tag_pkt_yumi_i       (tag_pkt_yumi_i),
      .data_pkt_o           (data_pkt_o),
      .data_pkt_v_o         (data_pkt_v_o),
      .data_pkt_yumi_i      (data_pkt_yumi_i),
      .mem_cmd_o            (mem_cmd_o),
      .mem_cmd_v_o          (mem_cmd_v_o),
      .mem_cmd_ready_i      (mem_cmd_ready_i),
      .beat_i               (beat),
      .beat_v_i             (beat_v),
      .beat_ready_o         (beat_ready)
    );

  uce_resp_pump pump0
    (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .mem_resp_i       (mem_resp_i),
      .mem_resp_v_i     (mem_resp_v_i),
      .mem_resp_ready_o (mem_resp_ready_o),
      .beat_o           (beat),
      .beat_v_o         (beat_v),
      .beat_ready_i     (beat_ready)
    );

endmodule

`default_nettype wire

//--- tb.f
+incdir+common
+incdir+verif
common/uce_pkg.sv
design/uce_resp_pump.sv
uce_ctrl/uce_ctrl.sv
design/uce_top.sv
verif/uce_tb.sv

//--- uce_ctrl/uce_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "uce_cfg.svh"

module uce_ctrl
  (
    input  logic                    clk_i,
    input  logic                    reset_i,

    input  uce_pkg::uce_cache_req_s cache_req_i,
    input  logic                    cache_req_v_i,
    output logic                    cache_req_ready_o,
    output logic                    cache_req_complete_o,
    output logic                    cache_req_busy_o,

    output uce_pkg::uce_tag_pkt_s   tag_pkt_o,
    output logic                    tag_pkt_v_o,
    input  logic                    tag_pkt_yumi_i,

    output uce_pkg::uce_data_pkt_s  data_pkt_o,
    output logic                    data_pkt_v_o,
    input  logic                    data_pkt_yumi_i,

    output uce_pkg::uce_mem_cmd_s   mem_cmd_o,
    output logic                    mem_cmd_v_o,
    input  logic                    mem_cmd_ready_i,

    input  uce_pkg::uce_resp_beat_s beat_i,
    input  logic                    beat_v_i,
    output logic                    beat_ready_o
  );

  import uce_pkg::*;

  localparam int unsigned credit_width = $clog2(`UCE_MAX_CREDITS + 1);

  typedef enum logic [2:0]
  {
    e_reset,
    e_clear,
    e_ready,
    e_send,
    e_fill_wait,
    e_uc_read_wait
  } state_e;

  state_e                  state_r;
  state_e                  state_n;
  uce_cache_req_s          req_r;
  logic [index_width-1:0]  clear_idx_r;
  logic [credit_width-1:0] credit_cnt_r;
  logic                    tag_done_r;
  logic                    data_done_r;

  logic                    req_hs;
  logic                    credits_full;
  logic                    credit_take;
  logic                    credit_return;
  logic                    clear_hs;
  logic                    clear_last;
  logic                    store_resp_v;
  logic                    load_resp_v;
  logic                    load_yumi;
  logic                    fill_tag_hs;
  logic                    fill_data_hs;
  logic [index_width-1:0]  beat_index;
  logic [tag_width-1:0]    beat_tag;

  assign credits_full = (credit_cnt_r == credit_width'(`UCE_MAX_CREDITS));
  assign cache_req_busy_o = (state_r == e_reset) | (state_r == e_clear) | credits_full;
  assign cache_req_ready_o = (state_r == e_ready) & ~cache_req_busy_o;
  assign req_hs = cache_req_ready_o & cache_req_v_i;
  assign clear_last = (clear_idx_r == index_width'(`UCE_SETS - 1));

  assign beat_index = beat_i.addr[block_offset_width +: index_width];
  assign beat_tag = beat_i.addr[paddr_width-1 -: tag_width];

  // Store acks are drained in any state, every other response waits for its state
  assign store_resp_v = beat_v_i & (beat_i.header.msg_type == e_mem_uc_wr);
  assign load_resp_v = beat_v_i & (beat_i.header.msg_type != e_mem_uc_wr);
  assign beat_ready_o = store_resp_v | load_yumi;

  assign credit_take = mem_cmd_v_o & mem_cmd_ready_i;
  assign credit_return = beat_v_i & beat_ready_o & beat_i.last;

  always_comb
  begin
    mem_cmd_o = '0;
    mem_cmd_o.header.addr = req_r.addr;
    mem_cmd_o.header.size = req_r.size;
    mem_cmd_o.data = {(fill_width / dword_width){req_r.data}};
    case (req_r.msg_type)
      e_req_miss_load:
      begin
        // Fills always fetch the whole block from its first byte
        mem_cmd_o.header.msg_type = e_mem_rd;
        mem_cmd_o.header.addr =
          {req_r.addr[paddr_width-1:block_offset_width], block_offset_width'(0)};
        mem_cmd_o.header.size = block_size_code;
      end
      e_req_uc_load:
        mem_cmd_o.header.msg_type = e_mem_uc_rd;
      default:
        mem_cmd_o.header.msg_type = e_mem_uc_wr;
    endcase
  end

  always_comb
  begin
    state_n = state_r;
    tag_pkt_o = '0;
    tag_pkt_v_o = 1'b0;
    data_pkt_o = '0;
    data_pkt_v_o = 1'b0;
    mem_cmd_v_o = 1'b0;
    cache_req_complete_o = 1'b0;
    clear_hs = 1'b0;
    fill_tag_hs = 1'b0;
    fill_data_hs = 1'b0;
    load_yumi = 1'b0;

    case (state_r)
      e_reset:
        state_n = e_clear;
      e_clear:
      begin
        tag_pkt_o.opcode = e_tag_clear;
        tag_pkt_o.index = clear_idx_r;
        tag_pkt_v_o = 1'b1;
        clear_hs = tag_pkt_yumi_i;
        cache_req_complete_o = clear_hs & clear_last;
        if (cache_req_complete_o)
          state_n = e_ready;
      end
      e_ready:
      begin
        if (req_hs)
          state_n = (cache_req_i.msg_type == e_req_clear) ? e_clear : e_send;
      end
      e_send:
      begin
        mem_cmd_v_o = ~credits_full;
        if (mem_cmd_v_o & mem_cmd_ready_i)
        begin
          // Stores do not wait for their ack
          cache_req_complete_o = (req_r.msg_type == e_req_uc_store);
          case (req_r.msg_type)
            e_req_miss_load:
              state_n = e_fill_wait;
            e_req_uc_load:
              state_n = e_uc_read_wait;
            default:
              state_n = e_ready;
          endcase
        end
      end
      e_fill_wait:
      begin
        tag_pkt_o.opcode = e_tag_set_tag;
        tag_pkt_o.index = beat_index;
        tag_pkt_o.way = req_r.way;
        tag_pkt_o.tag = beat_tag;
        tag_pkt_v_o = load_resp_v & ~tag_done_r;

        data_pkt_o.opcode = e_data_write;
        data_pkt_o.index = beat_index;
        data_pkt_o.way = req_r.way;
        data_pkt_o.fill_index = beat_i.fill_index;
        data_pkt_o.data = beat_i.data;
        data_pkt_v_o = load_resp_v & ~data_done_r;

        fill_tag_hs = tag_pkt_v_o & tag_pkt_yumi_i;
        fill_data_hs = data_pkt_v_o & data_pkt_yumi_i;
        // A beat retires once both arrays have taken their packet, in any order
        load_yumi = load_resp_v & (tag_done_r | fill_tag_hs) & (data_done_r | fill_data_hs);
        cache_req_complete_o = load_yumi & beat_i.last;
        if (cache_req_complete_o)
          state_n = e_ready;
      end
      e_uc_read_wait:
      begin
        data_pkt_o.opcode = e_data_uncached;
        data_pkt_o.index = req_r.addr[block_offset_width +: index_width];
        data_pkt_o.way = req_r.way;
        data_pkt_o.data = {(fill_width / dword_width){beat_i.data[dword_width-1:0]}};
        data_pkt_v_o = load_resp_v;
        load_yumi = data_pkt_v_o & data_pkt_yumi_i;
        cache_req_complete_o = load_yumi;
        if (cache_req_complete_o)
          state_n = e_ready;
      end
      default:
        state_n = e_reset;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (req_hs)
      req_r <= cache_req_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_reset;
      clear_idx_r <= '0;
      credit_cnt_r <= '0;
      tag_done_r <= 1'b0;
      data_done_r <= 1'b0;
    end
    else
    begin
      state_r <= state_n;

      if (clear_hs)
        clear_idx_r <= clear_last ? '0 : clear_idx_r + index_width'(1);

      if (credit_take & ~credit_return)
        credit_cnt_r <= credit_cnt_r + credit_width'(1);
      else if (~credit_take & credit_return)
        credit_cnt_r <= credit_cnt_r - credit_width'(1);

      if (load_yumi)
        tag_done_r <= 1'b0;
      else if (fill_tag_hs)
        tag_done_r <= 1'b1;

      if (load_yumi)
        data_done_r <= 1'b0;
      else if (fill_data_hs)
        data_done_r <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- verif/uce_tb_tests.svh
`ifndef UCE_TB_TESTS_SVH
`define UCE_TB_TESTS_SVH

// Read data is the beat address xor a constant in the upper half and its inverse in the lower half
function automatic logic [`UCE_FILL_WIDTH-1:0] fill_pattern(input logic [31:0] addr);
  return {addr ^ 32'h9e37_79b9, ~addr};
endfunction

task automatic check_eq(input string what, input logic [127:0] actual,
                        input logic [127:0] expected);
  checks++;
  if (actual !== expected)
  begin
    errors++;
    test_errors++;
    $display("error at %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
  end
endtask

task automatic note_failure(input string msg);
  errors++;
  test_errors++;
  $display("%s", msg);
endtask

task automatic start_test();
  test_errors = 0;
  cmd_log.delete();
  tag_q.delete();
  data_q.delete();
endtask

task automatic finish_test(input string name);
  tests_run++;
  if (test_errors == 0)
    $display("test %s: passed", name);
  else
  begin
    tests_failed++;
    $display("test %s: failed with %0d errors", name, test_errors);
  end
endtask

task automatic send_req(input uce_cache_req_s req);
  int cycles;
  bit taken;
  cycles = 0;
  taken = 1'b0;
  @(negedge clk_i);
  cache_req_i = req;
  cache_req_v_i = 1'b1;
  while (!taken && cycles < 200)
  begin
    #(sample_delay);
    taken = cache_req_ready_o;
    cycles++;
    @(negedge clk_i);
  end
  cache_req_v_i = 1'b0;
  if (!taken)
    note_failure("timeout: the DUT never became ready for a request");
endtask

task automatic wait_complete(input int target, input int limit, input string what);
  int cycles;
  cycles = 0;
  while (complete_cnt < target && cycles < limit)
  begin
    @(negedge clk_i);
    cycles++;
  end
  if (complete_cnt < target)
    note_failure($sformatf("timeout: %s did not complete in %0d cycles", what, limit));
endtask

// Starts at a falling edge while the tag clear is running
task automatic clear_sequence();
  int cycles;
  bit done;
  cycles = 0;
  done = 1'b0;
  while (!done && cycles < 8 * `UCE_SETS)
  begin
    #(sample_delay);
    if (cache_req_complete_o)
      done = 1'b1;
    else
      check_eq("busy during clear", 128'(cache_req_busy_o), 128'(1));
    cycles++;
    @(negedge clk_i);
  end
  if (!done)
    note_failure("timeout: the tag clear never completed");
  else
  begin
    #(sample_delay);
    check_eq("ready after clear", 128'(cache_req_ready_o), 128'(1));
    check_eq("busy after clear", 128'(cache_req_busy_o), 128'(0));
    @(negedge clk_i);
  end
  check_eq("clear packet count", 128'(tag_q.size()), 128'(`UCE_SETS));
  for (int i = 0; i < tag_q.size(); i++)
  begin
    check_eq("clear opcode", 128'(tag_q[i].opcode), 128'(e_tag_clear));
    check_eq("clear index", 128'(tag_q[i].index), 128'(i));
  end
endtask

task automatic reset_clear_test();
  start_test();
  clear_sequence();
  finish_test("reset clear");
endtask

task automatic load_miss_test();
  uce_cache_req_s req;
  logic [31:0]    block;
  logic [31:0]    baddr;
  int             base;
  start_test();
  yumi_pct = 50;
  for (int n = 0; n < 2; n++)
  begin
    cmd_log.delete();
    tag_q.delete();
    data_q.delete();
    req = '0;
    req.msg_type = e_req_miss_load;
    req.addr = next_rand() ^ (next_rand() << 8);
    req.size = 3'd3;
    req.way = way_bits'(n + 1);
    base = complete_cnt;
    send_req(req);
    wait_complete(base + 1, 100, "load miss");
    block = req.addr & ~32'(block_bytes - 1);
    check_eq("fill command count", 128'(cmd_log.size()), 128'(1));
    if (cmd_log.size() > 0)
    begin
      check_eq("fill command type", 128'(cmd_log[0].header.msg_type), 128'(e_mem_rd));
      check_eq("fill command address", 128'(cmd_log[0].header.addr), 128'(block));
      check_eq("fill command size", 128'(cmd_log[0].header.size), 128'(block_shift));
    end
    check_eq("fill tag packets", 128'(tag_q.size()), 128'(beats_per_block));
    check_eq("fill data packets", 128'(data_q.size()), 128'(beats_per_block));
    for (int b = 0; b < beats_per_block && b < tag_q.size() && b < data_q.size(); b++)
    begin
      baddr = block + 32'(b * fill_bytes);
      check_eq("tag opcode", 128'(tag_q[b].opcode), 128'(e_tag_set_tag));
      check_eq("tag index", 128'(tag_q[b].index), 128'((baddr >> block_shift) % `UCE_SETS));
      check_eq("tag way", 128'(tag_q[b].way), 128'(req.way));
      check_eq("tag value", 128'(tag_q[b].tag), 128'(baddr >> tag_shift));
      check_eq("data opcode", 128'(data_q[b].opcode), 128'(e_data_write));
      check_eq("data index", 128'(data_q[b].index), 128'((baddr >> block_shift) % `UCE_SETS));
      check_eq("data way", 128'(data_q[b].way), 128'(req.way));
      check_eq("data fill index", 128'(data_q[b].fill_index), 128'(1) << b);
      check_eq("data value", 128'(data_q[b].data), 128'(fill_pattern(baddr)));
    end
  end
  yumi_pct = 75;
  finish_test("load miss fill");
endtask

task automatic uncached_load_test();
  uce_cache_req_s                req;
  logic [`UCE_FILL_WIDTH-1:0]    beat_data;
  logic [`UCE_DWORD_WIDTH-1:0]   dword;
  int                            base;
  start_test();
  req = '0;
  req.msg_type = e_req_uc_load;
  req.addr = next_rand() ^ (next_rand() << 8);
  req.size = 3'd3;
  base = complete_cnt;
  send_req(req);
  wait_complete(base + 1, 100, "uncached load");
  beat_data = fill_pattern(req.addr);
  dword = beat_data[`UCE_DWORD_WIDTH-1:0];
  check_eq("uncached command count", 128'(cmd_log.size()), 128'(1));
  if (cmd_log.size() > 0)
  begin
    check_eq("uncached command type", 128'(cmd_log[0].header.msg_type), 128'(e_mem_uc_rd));
    check_eq("uncached command address", 128'(cmd_log[0].header.addr), 128'(req.addr));
    check_eq("uncached command size", 128'(cmd_log[0].header.size), 128'(3));
  end
  check_eq("uncached data packets", 128'(data_q.size()), 128'(1));
  if (data_q.size() > 0)
  begin
    check_eq("uncached opcode", 128'(data_q[0].opcode), 128'(e_data_uncached));
    check_eq("uncached data", 128'(data_q[0].data),
      128'({(`UCE_FILL_WIDTH / `UCE_DWORD_WIDTH){dword}}));
  end
  finish_test("uncached load");
endtask

task automatic store_credit_test();
  uce_cache_req_s stores[`UCE_MAX_CREDITS];
  int             base;
  int             cycles;
  bit             done;
  start_test();
  hold_acks = 1'b1;
  ack_release = 0;
  for (int i = 0; i < `UCE_MAX_CREDITS; i++)
  begin
    stores[i] = '0;
    stores[i].msg_type = e_req_uc_store;
    stores[i].addr = next_rand() ^ (next_rand() << 8);
    stores[i].size = 3'd3;
    stores[i].data = {next_rand() ^ (next_rand() << 8), next_rand() ^ (next_rand() << 8)};
    base = complete_cnt;
    send_req(stores[i]);
    wait_complete(base + 1, 100, "uncached store");
  end
  #(sample_delay);
  check_eq("busy with credits full", 128'(cache_req_busy_o), 128'(1));
  check_eq("ready with credits full", 128'(cache_req_ready_o), 128'(0));
  check_eq("store command count", 128'(cmd_log.size()), 128'(`UCE_MAX_CREDITS));
  for (int i = 0; i < cmd_log.size() && i < `UCE_MAX_CREDITS; i++)
  begin
    check_eq("store command type", 128'(cmd_log[i].header.msg_type), 128'(e_mem_uc_wr));
    check_eq("store command address", 128'(cmd_log[i].header.addr), 128'(stores[i].addr));
    check_eq("store command data", 128'(cmd_log[i].data),
      128'({(`UCE_FILL_WIDTH / `UCE_DWORD_WIDTH){stores[i].data}}));
  end
  ack_release = 1;
  cycles = 0;
  done = 1'b0;
  while (!done && cycles < 100)
  begin
    @(negedge clk_i);
    #(sample_delay);
    done = !cache_req_busy_o;
    cycles++;
  end
  if (!done)
    note_failure("timeout: busy stayed high after one store ack was released");
  hold_acks = 1'b0;
  cycles = 0;
  while ((pend_q.size() > 0 || resp_active) && cycles < 200)
  begin
    @(negedge clk_i);
    cycles++;
  end
  if (pend_q.size() > 0 || resp_active)
    note_failure("timeout: the remaining store acks were never taken");
  @(negedge clk_i);
  finish_test("uncached store credits");
endtask

task automatic clear_request_test();
  uce_cache_req_s req;
  start_test();
  req = '0;
  req.msg_type = e_req_clear;
  send_req(req);
  clear_sequence();
  finish_test("clear request");
endtask

`endif

//--- verif/uce_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "uce_cfg.svh"

module uce_tb;

  import uce_pkg::*;

  localparam int clk_period = 40;
  localparam int sample_delay = clk_period / 2 - 1;
  localparam int reset_cycles = 5;
  localparam int fill_bytes = `UCE_FILL_WIDTH / 8;
  localparam int block_bytes = `UCE_BLOCK_WIDTH / 8;
  localparam int block_shift = $clog2(block_bytes);
  localparam int tag_shift = block_shift + $clog2(`UCE_SETS);
  localparam int way_bits = $clog2(`UCE_WAYS);
  localparam int beats_per_block = `UCE_BLOCK_WIDTH / `UCE_FILL_WIDTH;
  // Two clears, two fills, one uncached load and the store burst, in cycles
  localparam int test_cycles = 2 * `UCE_SETS + 3 * 16 + (`UCE_MAX_CREDITS + 2) * 16;
  localparam int watchdog_ns = (test_cycles * 4 + 200) * clk_period;

  logic           clk_i;
  logic           reset_i;
  uce_cache_req_s cache_req_i;
  logic           cache_req_v_i;
  logic           cache_req_ready_o;
  logic           cache_req_complete_o;
  logic           cache_req_busy_o;
  uce_tag_pkt_s   tag_pkt_o;
  logic           tag_pkt_v_o;
  logic           tag_pkt_yumi_i;
  uce_data_pkt_s  data_pkt_o;
  logic           data_pkt_v_o;
  logic           data_pkt_yumi_i;
  uce_mem_cmd_s   mem_cmd_o;
  logic           mem_cmd_v_o;
  logic           mem_cmd_ready_i;
  uce_mem_resp_s  mem_resp_i;
  logic           mem_resp_v_i;
  logic           mem_resp_ready_o;

  logic [31:0]    seed = 32'd16;
  int             yumi_pct = 75;
  int             errors = 0;
  int             checks = 0;
  int             test_errors = 0;
  int             tests_run = 0;
  int             tests_failed = 0;
  int             complete_cnt = 0;
  int             ack_release = 0;
  bit             hold_acks = 1'b0;
  bit             resp_active = 1'b0;
  uce_mem_cmd_s   cmd_log[$];
  uce_mem_cmd_s   pend_q[$];
  uce_tag_pkt_s   tag_q[$];
  uce_data_pkt_s  data_q[$];

  uce_top dut0
    (
      .clk_i                (clk_i),
      .reset_i              (reset_i),
      .cache_req_i          (cache_req_i),
      .cache_req_v_i        (cache_req_v_i),
      .cache_req_ready_o    (cache_req_ready_o),
      .cache_req_complete_o (cache_req_complete_o),
      .cache_req_busy_o     (cache_req_busy_o),
      .tag_pkt_o            (tag_pkt_o),
      .tag_pkt_v_o          (tag_pkt_v_o),
      .tag_pkt_yumi_i       (tag_pkt_yumi_i),
      .data_pkt_o           (data_pkt_o),
      .data_pkt_v_o         (data_pkt_v_o),
      .data_pkt_yumi_i      (data_pkt_yumi_i),
      .mem_cmd_o            (mem_cmd_o),
      .mem_cmd_v_o          (mem_cmd_v_o),
      .mem_cmd_ready_i      (mem_cmd_ready_i),
      .mem_resp_i           (mem_resp_i),
      .mem_resp_v_i         (mem_resp_v_i),
      .mem_resp_ready_o     (mem_resp_ready_o)
    );

  `include "uce_tb_tests.svh"

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return {8'd0, seed[31:8]};
  endfunction

  function automatic bit rand_chance(input int pct);
    return (next_rand() % 32'd100) < 32'(pct);
  endfunction

  initial
  begin : clock_gen
    clk_i = 1'b0;
    forever
    begin
      #(clk_period / 2);
      clk_i = ~clk_i;
    end
  end

  initial
  begin : main
    reset_i = 1'b1;
    cache_req_i = '0;
    cache_req_v_i = 1'b0;
    repeat (reset_cycles) @(negedge clk_i);
    reset_i = 1'b0;
    reset_clear_test();
    load_miss_test();
    uncached_load_test();
    store_credit_test();
    clear_request_test();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
      tests_run, tests_failed, checks, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  initial
  begin : watchdog
    #(watchdog_ns);
    $display("timeout: the run did not finish within %0d ns", watchdog_ns);
    $display("SOME TESTS FAILED");
    $finish;
  end

  // Handshakes are sampled just before the rising edge, when every input has settled
  initial
  begin : cmd_acceptor
    mem_cmd_ready_i = 1'b0;
    forever
    begin
      @(negedge clk_i);
      mem_cmd_ready_i = rand_chance(70);
      #(sample_delay);
      if (mem_cmd_v_o && mem_cmd_ready_i)
      begin
        cmd_log.push_back(mem_cmd_o);
        pend_q.push_back(mem_cmd_o);
      end
    end
  end

  initial
  begin : mem_responder
    uce_mem_cmd_s cur;
    int           beat;
    int           beats;
    bit           take;
    cur = '0;
    beat = 0;
    beats = 1;
    mem_resp_i = '0;
    mem_resp_v_i = 1'b0;
    forever
    begin
      @(negedge clk_i);
      if (!resp_active && pend_q.size() > 0 && rand_chance(60))
      begin
        take = 1'b1;
        // Held store acks also block whatever is queued behind them
        if (pend_q[0].header.msg_type == e_mem_uc_wr && hold_acks)
        begin
          take = (ack_release > 0);
          if (take)
            ack_release--;
        end
        if (take)
        begin
          cur = pend_q.pop_front();
          beats = (cur.header.msg_type == e_mem_rd) ? beats_per_block : 1;
          beat = 0;
          resp_active = 1'b1;
        end
      end
      mem_resp_v_i = resp_active;
      mem_resp_i.header = cur.header;
      mem_resp_i.data = (cur.header.msg_type == e_mem_uc_wr) ? '0 :
        fill_pattern(cur.header.addr + 32'(beat * fill_bytes));
      mem_resp_i.last = (beat == beats - 1);
      #(sample_delay);
      if (mem_resp_v_i && mem_resp_ready_o)
      begin
        if (mem_resp_i.last)
          resp_active = 1'b0;
        else
          beat++;
      end
    end
  end

  initial
  begin : tag_acceptor
    tag_pkt_yumi_i = 1'b0;
    forever
    begin
      @(negedge clk_i);
      tag_pkt_yumi_i = rand_chance(yumi_pct);
      #(sample_delay);
      if (tag_pkt_v_o && tag_pkt_yumi_i)
        tag_q.push_back(tag_pkt_o);
    end
  end

  initial
  begin : data_acceptor
    data_pkt_yumi_i = 1'b0;
    forever
    begin
      @(negedge clk_i);
      data_pkt_yumi_i = rand_chance(yumi_pct);
      #(sample_delay);
      if (data_pkt_v_o && data_pkt_yumi_i)
        data_q.push_back(data_pkt_o);
    end
  end

  initial
  begin : complete_monitor
    forever
    begin
      @(negedge clk_i);
      #(sample_delay);
      if (cache_req_complete_o)
        complete_cnt++;
    end
  end

endmodule

`default_nettype wire
